// File: hdl/isaPkg.sv
`default_nettype none

// Instruction set of the 16-bit teaching ISA
package isaPkg;

   ////////////////////////////////////////////////////////////
   // Field widths and word types
   ////////////////////////////////////////////////////////////
   localparam int wordW   = 16;
   localparam int regIdxW = 3;
   localparam int opcodeW = 5;
   localparam int imm5W   = 5;

   typedef logic [wordW-1:0]   word_t;
   typedef logic [regIdxW-1:0] regIdx_t;
   typedef logic [opcodeW-1:0] opcode_t;

   ////////////////////////////////////////////////////////////
   // Opcodes
   ////////////////////////////////////////////////////////////
   localparam opcode_t opNop        = 5'b00001;
   localparam opcode_t opJ          = 5'b00100;
   localparam opcode_t opJr         = 5'b00101;

   // Immediate arithmetic, low two bits pick the operation
   localparam opcode_t opAddi       = 5'b01000;
   localparam opcode_t opSubi       = 5'b01001;
   localparam opcode_t opXori       = 5'b01010;
   localparam opcode_t opAndni      = 5'b01011;

   // Branches on Rs, low two bits pick the condition
   localparam opcode_t opBeqz       = 5'b01100;
   localparam opcode_t opBnez       = 5'b01101;
   localparam opcode_t opBltz       = 5'b01110;
   localparam opcode_t opBgez       = 5'b01111;

   localparam opcode_t opSlbi       = 5'b10010;

   // Immediate rotates and shifts
   localparam opcode_t opRoli       = 5'b10100;
   localparam opcode_t opSlli       = 5'b10101;
   localparam opcode_t opRori       = 5'b10110;
   localparam opcode_t opSrli       = 5'b10111;

   localparam opcode_t opLbi        = 5'b11000;
   localparam opcode_t opBtr        = 5'b11001;

   // R-format groups, funct picks the operation
   localparam opcode_t opRformShift = 5'b11010;
   localparam opcode_t opRformArith = 5'b11011;

   // Set-condition group
   localparam opcode_t opSeq        = 5'b11100;
   localparam opcode_t opSlt        = 5'b11101;
   localparam opcode_t opSle        = 5'b11110;
   localparam opcode_t opSco        = 5'b11111;

   ////////////////////////////////////////////////////////////
   // Two views of one instruction word
   ////////////////////////////////////////////////////////////
   typedef union packed {
      struct packed {
         opcode_t      opcode;
         regIdx_t      rs;
         regIdx_t      rt;
         regIdx_t      rd;
         logic [1:0]   funct;
      } rForm;
      struct packed {
         opcode_t          opcode;
         regIdx_t          rs;
         regIdx_t          rd;
         logic [imm5W-1:0] imm5;
      } iForm;
   } instr_u;

endpackage

`default_nettype wire

// File: hdl/pipePkg.sv
`default_nettype none

// Pipeline control codes shared between the stages
package pipePkg;

   // Operand source for execute
   typedef logic [1:0] fwdSel_t;

   localparam fwdSel_t fwdFromReg    = 2'b00;
   // Reserved, commit port is the execute register
   localparam fwdSel_t fwdFromCommit = 2'b01;
   localparam fwdSel_t fwdFromExec   = 2'b10;

   // ALU operation, rotates and shifts in the low half
   typedef logic [2:0] aluOp_t;

   localparam aluOp_t aluRol = 3'b000;
   localparam aluOp_t aluSll = 3'b001;
   localparam aluOp_t aluRor = 3'b010;
   localparam aluOp_t aluSrl = 3'b011;
   localparam aluOp_t aluAdd = 3'b100;
   localparam aluOp_t aluAnd = 3'b101;
   localparam aluOp_t aluOr  = 3'b110;
   localparam aluOp_t aluXor = 3'b111;

   // Bubble loaded into decode on squash or idle cycles
   localparam isaPkg::word_t nopWord = {isaPkg::opNop, 11'b0};

endpackage

`default_nettype wire

// File: hdl/regFile.sv
`default_nettype none

module regFile import isaPkg::*; (
   input  logic    clk,
   input  logic    rstN,
   input  regIdx_t rdAddrA,
   input  regIdx_t rdAddrB,
   input  logic    wrEn,
   input  regIdx_t wrAddr,
   input  word_t   wrData,
   output word_t   rdDataA,
   output word_t   rdDataB
);

   // Eight architectural registers
   word_t regs [2**regIdxW];

   // Write port, fed from the execute register
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < 2**regIdxW; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Read ports
   // Same-cycle write is passed straight through
   assign rdDataA = (wrEn && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
   assign rdDataB = (wrEn && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

endmodule

`default_nettype wire

// File: hdl/decodeStage.sv
`default_nettype none

module decodeStage import isaPkg::*, pipePkg::*; (
   input  logic    clk,
   input  logic    rstN,
   input  logic    instrValid,
   input  word_t   instr,
   input  word_t   incrPC,
   input  logic    squash,
   input  logic    wrEn,
   input  regIdx_t wrAddr,
   input  word_t   wrData,
   output instr_u  idInstr,
   output word_t   idIncrPC,
   output logic    idValid,
   output word_t   idOpA,
   output word_t   idOpB,
   output regIdx_t idDest,
   output logic    idWrEn,
   output regIdx_t rs,
   output regIdx_t rt,
   output logic    rsValid,
   output logic    rtValid
);

   instr_u  cur;
   word_t   rdA;
   word_t   rdB;
   regIdx_t dest;
   logic    writes;
   logic    srcA;
   logic    srcB;
   logic    accept;

   assign cur = instr;

   // Incoming word is kept only when valid and not on the wrong path
   assign accept = instrValid & ~squash;

   regFile uRegFile (
      .clk     (clk),
      .rstN    (rstN),
      .rdAddrA (cur.rForm.rs),
      .rdAddrB (cur.rForm.rt),
      .wrEn    (wrEn),
      .wrAddr  (wrAddr),
      .wrData  (wrData),
      .rdDataA (rdA),
      .rdDataB (rdB)
   );

   ////////////////////////////////////////////////////////////
   // Source and destination decode
   ////////////////////////////////////////////////////////////
   always_comb begin
      dest   = cur.rForm.rd;
      writes = 1'b0;
      srcA   = 1'b0;
      srcB   = 1'b0;
      case (cur.rForm.opcode)
         // Three-register forms
         opRformArith, opRformShift, opSeq, opSlt, opSle, opSco: begin
            writes = 1'b1;
            srcA   = 1'b1;
            srcB   = 1'b1;
         end
         // Rs only, still R-format destination
         opBtr: begin
            writes = 1'b1;
            srcA   = 1'b1;
         end
         opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli: begin
            dest   = cur.iForm.rd;
            writes = 1'b1;
            srcA   = 1'b1;
         end
         // Rs is the target here
         opLbi: begin
            dest   = cur.iForm.rs;
            writes = 1'b1;
         end
         opSlbi: begin
            dest   = cur.iForm.rs;
            writes = 1'b1;
            srcA   = 1'b1;
         end
         // Test or jump on Rs, no writeback
         opBeqz, opBnez, opBltz, opBgez, opJr: begin
            srcA = 1'b1;
         end
         opJ, opNop: begin
            writes = 1'b0;
         end
         default: begin
            writes = 1'b0;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Decode pipeline register
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         idValid <= 1'b0;
         idWrEn  <= 1'b0;
         rsValid <= 1'b0;
         rtValid <= 1'b0;
      end else begin
         idValid <= accept;
         idWrEn  <= accept & writes;
         rsValid <= accept & srcA;
         rtValid <= accept & srcB;
      end
   end

   // Payload, bubble word whenever nothing is accepted
   always_ff @(posedge clk) begin
      idInstr  <= accept ? cur : nopWord;
      idIncrPC <= incrPC;
      idOpA    <= rdA;
      idOpB    <= rdB;
      idDest   <= dest;
      rs       <= cur.rForm.rs;
      rt       <= cur.rForm.rt;
   end

endmodule

`default_nettype wire

// File: hdl/forwardUnit.sv
`default_nettype none

module forwardUnit import isaPkg::*, pipePkg::*; (
   input  regIdx_t rs,
   input  regIdx_t rt,
   input  logic    rsValid,
   input  logic    rtValid,
   input  regIdx_t exDest,
   input  logic    exWrEn,
   output fwdSel_t fwdA,
   output fwdSel_t fwdB
);

   logic hitA;
   logic hitB;

   // Real source reading what the older instruction just produced
   assign hitA = rsValid && exWrEn && (rs == exDest);
   assign hitB = rtValid && exWrEn && (rt == exDest);

   // Older results are already in regFile
   assign fwdA = hitA ? fwdFromExec : fwdFromReg;
   assign fwdB = hitB ? fwdFromExec : fwdFromReg;

endmodule

`default_nettype wire

// File: hdl/aluCore.sv
`default_nettype none

module aluCore import isaPkg::*, pipePkg::*; (
   input  word_t  inA,
   input  word_t  inB,
   input  aluOp_t oper,
   input  logic   invA,
   input  logic   invB,
   input  logic   cin,
   input  logic   signedOp,
   output word_t  out,
   output logic   zero,
   output logic   ofl
);

   word_t      a;
   word_t      b;
   word_t      sum;
   logic       carry;
   logic [3:0] shamt;
   logic [2*wordW-1:0] rolFull;
   logic [2*wordW-1:0] rorFull;

   // Operand inversion ahead of every operation
   assign a = invA ? ~inA : inA;
   assign b = invB ? ~inB : inB;

   // Adder with carry out kept for SCO
   assign {carry, sum} = {1'b0, a} + {1'b0, b} + {{wordW{1'b0}}, cin};

   // Amount is the raw B input
   assign shamt = inB[3:0];

   // Rotates via a doubled word
   assign rolFull = {a, a} << shamt;
   assign rorFull = {a, a} >> shamt;

   ////////////////////////////////////////////////////////////
   // Operation select
   ////////////////////////////////////////////////////////////
   always_comb begin
      case (oper)
         aluRol:  out = rolFull[2*wordW-1:wordW];
         aluSll:  out = a << shamt;
         aluRor:  out = rorFull[wordW-1:0];
         aluSrl:  out = a >> shamt;
         aluAdd:  out = sum;
         aluAnd:  out = a & b;
         aluOr:   out = a | b;
         aluXor:  out = a ^ b;
         default: out = sum;
      endcase
   end

   assign zero = (out == '0);

   // Signed rule on the inverted operands, else plain carry
   assign ofl = signedOp ? ((a[wordW-1] == b[wordW-1]) && (sum[wordW-1] != a[wordW-1]))
                         : carry;

endmodule

`default_nettype wire

// File: hdl/executeStage.sv
`default_nettype none

module executeStage import isaPkg::*, pipePkg::*; (
   input  logic    clk,
   input  logic    rstN,
   input  instr_u  idInstr,
   input  word_t   idIncrPC,
   input  logic    idValid,
   input  word_t   idOpA,
   input  word_t   idOpB,
   input  regIdx_t idDest,
   input  logic    idWrEn,
   input  fwdSel_t fwdA,
   input  fwdSel_t fwdB,
   output word_t   exResult,
   output regIdx_t exDest,
   output logic    exWrEn,
   output logic    pcSrc,
   output word_t   newPC,
   output logic    squash
);

   opcode_t    opc;
   word_t      opA;
   word_t      opB;
   word_t      aluA;
   word_t      aluB;
   word_t      aluOut;
   aluOp_t     aluOper;
   logic       invA;
   logic       invB;
   logic       signedOp;
   logic       aluZero;
   logic       aluOfl;
   logic       lessThan;
   logic       zeroExt;
   logic [1:0] arithSel;
   word_t      imm5Ext;
   word_t      imm8Sext;
   word_t      imm11Sext;
   word_t      result;
   word_t      target;
   logic       taken;

   assign opc = idInstr.rForm.opcode;

   ////////////////////////////////////////////////////////////
   // Operand forwarding
   ////////////////////////////////////////////////////////////
   always_comb begin
      case (fwdA)
         fwdFromExec, fwdFromCommit: opA = exResult;
         default:                    opA = idOpA;
      endcase
      case (fwdB)
         fwdFromExec, fwdFromCommit: opB = exResult;
         default:                    opB = idOpB;
      endcase
   end

   // XORI and ANDNI take the raw immediate
   assign zeroExt  = (opc == opXori) || (opc == opAndni);
   assign imm5Ext  = zeroExt ? {11'b0, idInstr.iForm.imm5}
                             : {{11{idInstr.iForm.imm5[4]}}, idInstr.iForm.imm5};
   assign imm8Sext  = {{8{idInstr[7]}}, idInstr[7:0]};
   assign imm11Sext = {{5{idInstr[10]}}, idInstr[10:0]};

   // Same two-bit code in funct and in the I-format opcode
   assign arithSel = (opc == opRformArith) ? idInstr.rForm.funct : opc[1:0];

   ////////////////////////////////////////////////////////////
   // ALU control and B operand
   ////////////////////////////////////////////////////////////
   always_comb begin
      aluA     = opA;
      aluB     = opB;
      aluOper  = aluAdd;
      invA     = 1'b0;
      invB     = 1'b0;
      signedOp = 1'b1;
      case (opc)
         opRformArith, opAddi, opSubi, opXori, opAndni: begin
            if (opc != opRformArith) begin
               aluB = imm5Ext;
            end
            case (arithSel)
               2'b00: aluOper = aluAdd;
               // B minus Rs
               2'b01: invA = 1'b1;
               2'b10: aluOper = aluXor;
               default: begin
                  aluOper = aluAnd;
                  invB    = 1'b1;
               end
            endcase
         end
         opRformShift: aluOper = {1'b0, idInstr.rForm.funct};
         opRoli, opSlli, opRori, opSrli: begin
            aluB    = imm5Ext;
            aluOper = {1'b0, opc[1:0]};
         end
         // Rs minus Rt, flags decide
         opSeq, opSlt, opSle: invB = 1'b1;
         // Unsigned carry of Rs plus Rt
         opSco: signedOp = 1'b0;
         opLbi: begin
            aluA = '0;
            aluB = imm8Sext;
         end
         opSlbi: begin
            aluA = '0;
            aluB = {opA[7:0], idInstr[7:0]};
         end
         // Target formed by the ALU
         opJr: aluB = imm8Sext;
         // Pass Rs through for reversal
         opBtr: aluB = '0;
         default: aluOper = aluAdd;
      endcase
   end

   aluCore uAlu (
      .inA      (aluA),
      .inB      (aluB),
      .oper     (aluOper),
      .invA     (invA),
      .invB     (invB),
      .cin      (invA | invB),
      .signedOp (signedOp),
      .out      (aluOut),
      .zero     (aluZero),
      .ofl      (aluOfl)
   );

   // Sign of the difference corrected for overflow
   assign lessThan = aluOut[wordW-1] ^ aluOfl;

   ////////////////////////////////////////////////////////////
   // Result select
   ////////////////////////////////////////////////////////////
   always_comb begin
      result = aluOut;
      case (opc)
         opSeq: result = {{(wordW-1){1'b0}}, aluZero};
         opSlt: result = {{(wordW-1){1'b0}}, lessThan};
         opSle: result = {{(wordW-1){1'b0}}, lessThan | aluZero};
         opSco: result = {{(wordW-1){1'b0}}, aluOfl};
         opBtr: begin
            for (int i = 0; i < wordW; i++) begin
               result[i] = aluOut[wordW-1-i];
            end
         end
         default: result = aluOut;
      endcase
   end

   // Branch test on forwarded Rs, target from incrPC by default
   always_comb begin
      taken  = 1'b0;
      target = idIncrPC + imm8Sext;
      case (opc)
         opBeqz: taken = (opA == '0);
         opBnez: taken = (opA != '0);
         opBltz: taken = opA[wordW-1];
         opBgez: taken = ~opA[wordW-1];
         opJ: begin
            taken  = 1'b1;
            target = idIncrPC + imm11Sext;
         end
         opJr: begin
            taken  = 1'b1;
            target = aluOut;
         end
         default: taken = 1'b0;
      endcase
   end

   // Kills the younger instruction entering decode
   assign squash = taken & idValid;

   ////////////////////////////////////////////////////////////
   // Execute pipeline register
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         exWrEn <= 1'b0;
         pcSrc  <= 1'b0;
      end else begin
         exWrEn <= idValid & idWrEn;
         pcSrc  <= squash;
      end
   end

   always_ff @(posedge clk) begin
      exResult <= result;
      exDest   <= idDest;
      newPC    <= target;
   end

endmodule

`default_nettype wire

// File: hdl/datapathTop.sv
`default_nettype none

module datapathTop import isaPkg::*, pipePkg::*; (
   input  logic    clk,
   input  logic    rstN,
   input  logic    instrValid,
   input  word_t   instr,
   input  word_t   incrPC,
   output logic    wbEn,
   output regIdx_t wbDest,
   output word_t   wbData,
   output logic    pcSrc,
   output word_t   newPC
);

   // Decode to execute
   instr_u  idInstr;
   word_t   idIncrPC;
   logic    idValid;
   word_t   idOpA;
   word_t   idOpB;
   regIdx_t idDest;
   logic    idWrEn;

   // Forwarding path
   regIdx_t rs;
   regIdx_t rt;
   logic    rsValid;
   logic    rtValid;
   fwdSel_t fwdA;
   fwdSel_t fwdB;
   logic    squash;

   // Execute register doubles as the commit port
   decodeStage uDecode (
      .clk        (clk),
      .rstN       (rstN),
      .instrValid (instrValid),
      .instr      (instr),
      .incrPC     (incrPC),
      .squash     (squash),
      .wrEn       (wbEn),
      .wrAddr     (wbDest),
      .wrData     (wbData),
      .idInstr    (idInstr),
      .idIncrPC   (idIncrPC),
      .idValid    (idValid),
      .idOpA      (idOpA),
      .idOpB      (idOpB),
      .idDest     (idDest),
      .idWrEn     (idWrEn),
      .rs         (rs),
      .rt         (rt),
      .rsValid    (rsValid),
      .rtValid    (rtValid)
   );

   forwardUnit uForward (
      .rs      (rs),
      .rt      (rt),
      .rsValid (rsValid),
      .rtValid (rtValid),
      .exDest  (wbDest),
      .exWrEn  (wbEn),
      .fwdA    (fwdA),
      .fwdB    (fwdB)
   );

   executeStage uExecute (
      .clk      (clk),
      .rstN     (rstN),
      .idInstr  (idInstr),
      .idIncrPC (idIncrPC),
      .idValid  (idValid),
      .idOpA    (idOpA),
      .idOpB    (idOpB),
      .idDest   (idDest),
      .idWrEn   (idWrEn),
      .fwdA     (fwdA),
      .fwdB     (fwdB),
      .exResult (wbData),
      .exDest   (wbDest),
      .exWrEn   (wbEn),
      .pcSrc    (pcSrc),
      .newPC    (newPC),
      .squash   (squash)
   );

endmodule

`default_nettype wire

// File: testbench/datapathTop_chk.sv
`default_nettype none

// Protocol checks on the pipeline outputs, bound into datapathTop
module datapathTop_chk (
   input logic clk,
   input logic rstN,
   input logic wbEn,
   input logic pcSrc,
   input logic squash
);

   timeunit 1ns;
   timeprecision 1ps;

   // Failed assertions so far, watched by the testbench
   int failCount = 0;

   ////////////////////////////////////////////////////////////
   // Redirect
   ////////////////////////////////////////////////////////////

   // Taken branch kills the next slot, so no second pulse
   redirectPulse: assert property (@(posedge clk) disable iff (!rstN) pcSrc |=> !pcSrc)
      else begin
         failCount = failCount + 1;
         $error("pcSrc high on two consecutive cycles");
      end

   ////////////////////////////////////////////////////////////
   // Commit port
   ////////////////////////////////////////////////////////////

   // Nothing commits while reset is held
   resetQuiet: assert property (@(posedge clk) !rstN |-> !wbEn)
      else begin
         failCount = failCount + 1;
         $error("wbEn high during reset");
      end

   // Branch itself, then the squashed slot, neither commits
   squashNoCommit: assert property (@(posedge clk) disable iff (!rstN)
                                    squash |=> !wbEn ##1 !wbEn)
      else begin
         failCount = failCount + 1;
         $error("commit seen in the slot after a squash");
      end

endmodule

bind datapathTop datapathTop_chk assertChk (
   .clk    (clk),
   .rstN   (rstN),
   .wbEn   (wbEn),
   .pcSrc  (pcSrc),
   .squash (squash)
);

`default_nettype wire

// File: testbench/datapathTb.sv
`default_nettype none

module datapathTb import isaPkg::*, pipePkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int resetCycles = 10;

   logic    clk;
   logic    rstN;
   logic    instrValid;
   word_t   instr;
   word_t   incrPC;
   logic    wbEn;
   regIdx_t wbDest;
   word_t   wbData;
   logic    pcSrc;
   word_t   newPC;

   // Stimulus table held as parallel queues indexed by row
   word_t   rowInstr[$];
   word_t   rowPC[$];
   logic    rowWbEn[$];
   regIdx_t rowDest[$];
   word_t   rowData[$];
   logic    rowPcSrc[$];
   word_t   rowNewPC[$];

   // Architectural state behind the expected values
   word_t   refRegs [8];
   word_t   nextPC;
   logic    squashNext;
   integer  seed;
   int      cycleCount = 0;
   int      cycleLimit = 0;

   datapathTop dut_i (
      .clk        (clk),
      .rstN       (rstN),
      .instrValid (instrValid),
      .instr      (instr),
      .incrPC     (incrPC),
      .wbEn       (wbEn),
      .wbDest     (wbDest),
      .wbData     (wbData),
      .pcSrc      (pcSrc),
      .newPC      (newPC)
   );

   // Starts high so the first falling edge comes at 5 ns
   initial begin
      clk = 1'b1;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Instruction encoding
   ////////////////////////////////////////////////////////////
   function automatic word_t encodeR(opcode_t op, regIdx_t rs, regIdx_t rt, regIdx_t rd,
                                     logic [1:0] funct);
      return {op, rs, rt, rd, funct};
   endfunction

   function automatic word_t encodeI(opcode_t op, regIdx_t rs, regIdx_t rd, logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   // LBI, SLBI, branches and JR
   function automatic word_t encodeB(opcode_t op, regIdx_t rs, logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic word_t encodeJ(opcode_t op, logic [10:0] offset);
      return {op, offset};
   endfunction

   ////////////////////////////////////////////////////////////
   // Reference arithmetic
   ////////////////////////////////////////////////////////////
   function automatic word_t rotLeft(word_t x, logic [3:0] n);
      word_t v;
      v = x;
      for (int i = 0; i < int'(n); i++) begin
         v = {v[14:0], v[15]};
      end
      return v;
   endfunction

   function automatic word_t rotRight(word_t x, logic [3:0] n);
      word_t v;
      v = x;
      for (int i = 0; i < int'(n); i++) begin
         v = {v[0], v[15:1]};
      end
      return v;
   endfunction

   function automatic word_t reverseBits(word_t x);
      word_t v;
      for (int i = 0; i < 16; i++) begin
         v[i] = x[15-i];
      end
      return v;
   endfunction

   // Appends one row and its expected commit and redirect
   task automatic addRow(input word_t w);
      opcode_t     op;
      regIdx_t     rsF;
      regIdx_t     dst;
      word_t       a;
      word_t       b;
      word_t       pc;
      word_t       sx5;
      word_t       zx5;
      word_t       sx8;
      word_t       res;
      word_t       tgt;
      logic [16:0] wide;
      logic        wr;
      logic        tk;
      op     = w[15:11];
      rsF    = w[10:8];
      a      = refRegs[rsF];
      b      = refRegs[w[7:5]];
      pc     = nextPC;
      nextPC = nextPC + 16'd2;
      sx5    = {{11{w[4]}}, w[4:0]};
      zx5    = {11'b0, w[4:0]};
      sx8    = {{8{w[7]}}, w[7:0]};
      dst    = w[7:5];
      res    = '0;
      tgt    = '0;
      wr     = 1'b1;
      tk     = 1'b0;
      case (op)
         opRformArith: begin
            dst = w[4:2];
            case (w[1:0])
               2'b00:   res = a + b;
               // Rt minus Rs
               2'b01:   res = b - a;
               2'b10:   res = a ^ b;
               default: res = a & ~b;
            endcase
         end
         opAddi:  res = a + sx5;
         opSubi:  res = sx5 - a;
         opXori:  res = a ^ zx5;
         opAndni: res = a & ~zx5;
         // Amount is the low four immediate bits
         opRoli:  res = rotLeft(a, w[3:0]);
         opSlli:  res = a << w[3:0];
         opRori:  res = rotRight(a, w[3:0]);
         opSrli:  res = a >> w[3:0];
         opRformShift: begin
            dst = w[4:2];
            case (w[1:0])
               2'b00:   res = rotLeft(a, b[3:0]);
               2'b01:   res = a << b[3:0];
               2'b10:   res = rotRight(a, b[3:0]);
               default: res = a >> b[3:0];
            endcase
         end
         opSeq: begin
            dst = w[4:2];
            res = {15'b0, a == b};
         end
         opSlt: begin
            dst = w[4:2];
            res = {15'b0, $signed(a) < $signed(b)};
         end
         opSle: begin
            dst = w[4:2];
            res = {15'b0, $signed(a) <= $signed(b)};
         end
         opSco: begin
            dst  = w[4:2];
            wide = {1'b0, a} + {1'b0, b};
            res  = {15'b0, wide[16]};
         end
         opBtr: begin
            dst = w[4:2];
            res = reverseBits(a);
         end
         opLbi: begin
            dst = rsF;
            res = sx8;
         end
         opSlbi: begin
            dst = rsF;
            res = {a[7:0], w[7:0]};
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            wr  = 1'b0;
            tgt = pc + sx8;
            case (op)
               opBeqz:  tk = (a == 16'h0000);
               opBnez:  tk = (a != 16'h0000);
               opBltz:  tk = a[15];
               default: tk = ~a[15];
            endcase
         end
         opJ: begin
            wr  = 1'b0;
            tk  = 1'b1;
            tgt = pc + {{5{w[10]}}, w[10:0]};
         end
         opJr: begin
            wr  = 1'b0;
            tk  = 1'b1;
            tgt = a + sx8;
         end
         default: wr = 1'b0;
      endcase
      // Younger slot after a taken branch leaves no trace
      if (squashNext) begin
         wr = 1'b0;
         tk = 1'b0;
      end
      if (wr) begin
         refRegs[dst] = res;
      end
      rowInstr.push_back(w);
      rowPC.push_back(pc);
      rowWbEn.push_back(wr);
      rowDest.push_back(dst);
      rowData.push_back(res);
      rowPcSrc.push_back(tk);
      rowNewPC.push_back(tgt);
      squashNext = tk;
   endtask

   ////////////////////////////////////////////////////////////
   // Table contents
   ////////////////////////////////////////////////////////////
   task automatic buildTable();
      logic [31:0] rnd;
      // Random register contents via LBI and a forwarded SLBI right behind it
      for (int r = 0; r < 6; r++) begin
         rnd = $random(seed);
         addRow(encodeB(opLbi, r[2:0], rnd[7:0]));
         addRow(encodeB(opSlbi, r[2:0], rnd[15:8]));
      end
      // r6 = 7FFF and r7 = 8000 for the overflow cases
      addRow(encodeB(opLbi, 3'd6, 8'h7F));
      addRow(encodeB(opSlbi, 3'd6, 8'hFF));
      addRow(encodeB(opLbi, 3'd7, 8'h80));
      addRow(encodeB(opSlbi, 3'd7, 8'h00));
      // Dependent chain where each row reads the previous two results
      addRow(encodeR(opRformArith, 3'd2, 3'd3, 3'd1, 2'b00));
      addRow(encodeR(opRformArith, 3'd1, 3'd4, 3'd2, 2'b01));
      addRow(encodeR(opRformArith, 3'd1, 3'd2, 3'd3, 2'b10));
      addRow(encodeR(opRformArith, 3'd3, 3'd5, 3'd4, 2'b11));
      addRow(encodeI(opAddi, 3'd4, 3'd5, 5'b11101));
      addRow(encodeI(opSubi, 3'd5, 3'd0, 5'b00111));
      addRow(encodeI(opXori, 3'd0, 3'd1, 5'b11111));
      addRow(encodeI(opAndni, 3'd1, 3'd2, 5'b10011));
      addRow(encodeI(opRoli, 3'd2, 3'd3, 5'd5));
      addRow(encodeI(opSlli, 3'd3, 3'd4, 5'b10100));
      addRow(encodeI(opRori, 3'd4, 3'd5, 5'd9));
      addRow(encodeI(opSrli, 3'd5, 3'd0, 5'd15));
      addRow(encodeR(opRformShift, 3'd2, 3'd3, 3'd1, 2'b00));
      addRow(encodeR(opRformShift, 3'd1, 3'd4, 3'd2, 2'b01));
      addRow(encodeR(opRformShift, 3'd2, 3'd5, 3'd3, 2'b10));
      addRow(encodeR(opRformShift, 3'd3, 3'd1, 3'd4, 2'b11));
      // Set conditions across the signed overflow boundary
      addRow(encodeR(opSeq, 3'd7, 3'd7, 3'd0, 2'b00));
      addRow(encodeR(opSeq, 3'd6, 3'd7, 3'd1, 2'b00));
      addRow(encodeR(opSlt, 3'd6, 3'd7, 3'd2, 2'b00));
      addRow(encodeR(opSlt, 3'd7, 3'd6, 3'd3, 2'b00));
      addRow(encodeR(opSle, 3'd7, 3'd7, 3'd4, 2'b00));
      addRow(encodeR(opSle, 3'd6, 3'd7, 3'd5, 2'b00));
      addRow(encodeR(opSco, 3'd6, 3'd7, 3'd0, 2'b00));
      addRow(encodeR(opSco, 3'd7, 3'd7, 3'd1, 2'b00));
      addRow(encodeR(opBtr, 3'd6, 3'd0, 3'd2, 2'b00));
      // Branches and jumps with the row after a taken one squashed
      addRow(encodeB(opLbi, 3'd3, 8'h00));
      addRow(encodeB(opBeqz, 3'd3, 8'h04));
      addRow(encodeI(opAddi, 3'd4, 3'd4, 5'd1));
      addRow(encodeB(opBnez, 3'd3, 8'hFE));
      addRow(encodeB(opBltz, 3'd7, 8'h10));
      addRow(encodeB(opLbi, 3'd5, 8'h55));
      addRow(encodeB(opBgez, 3'd7, 8'h20));
      addRow(encodeB(opBeqz, 3'd6, 8'h08));
      addRow(encodeB(opBgez, 3'd6, 8'hF8));
      addRow(encodeR(opRformArith, 3'd6, 3'd6, 3'd6, 2'b00));
      addRow(encodeJ(opJ, 11'h123));
      addRow(encodeR(opRformArith, 3'd0, 3'd0, 3'd0, 2'b10));
      addRow(encodeB(opLbi, 3'd4, 8'h40));
      addRow(encodeB(opJr, 3'd4, 8'h10));
      addRow(encodeB(opLbi, 3'd3, 8'h01));
      addRow(encodeB(opBnez, 3'd1, 8'h7F));
      addRow(encodeJ(opJ, 11'h7FF));
      // Squashed rows must not have touched r3, r5 or r6
      addRow(encodeR(opRformArith, 3'd4, 3'd5, 3'd0, 2'b00));
      addRow(encodeR(opRformArith, 3'd3, 3'd6, 3'd1, 2'b00));
      addRow(nopWord);
   endtask

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////
   task automatic stopRun();
      $display("TB FAILED");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic checkCommit(input logic expEn, input regIdx_t expDest, input word_t expData,
                              input int row);
      if (wbEn !== expEn) begin
         $display("Mismatch at %0t: row %0d wbEn expected %b, got %b",
                  $time, row, expEn, wbEn);
         stopRun();
      end else if (expEn && ((wbDest !== expDest) || (wbData !== expData))) begin
         $display("Mismatch at %0t: row %0d commit expected r%0d=%h, got r%0d=%h",
                  $time, row, expDest, expData, wbDest, wbData);
         stopRun();
      end
   endtask

   task automatic checkRedirect(input logic expSrc, input word_t expPC, input int row);
      if (pcSrc !== expSrc) begin
         $display("Mismatch at %0t: row %0d pcSrc expected %b, got %b",
                  $time, row, expSrc, pcSrc);
         stopRun();
      end else if (expSrc && (newPC !== expPC)) begin
         $display("Mismatch at %0t: row %0d newPC expected %h, got %h",
                  $time, row, expPC, newPC);
         stopRun();
      end
   endtask

   task automatic checkAsserts();
      if (dut_i.assertChk.failCount != 0) begin
         $display("A bound assertion on datapathTop failed, see the error above");
         stopRun();
      end
   endtask

   // Cycle budget from the table length
   always @(posedge clk) begin
      cycleCount = cycleCount + 1;
      if ((cycleLimit != 0) && (cycleCount > cycleLimit)) begin
         $display("Timeout after %0d cycles, the run did not finish", cycleCount);
         stopRun();
      end
   end

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////
   initial begin
      rstN       = 1'b1;
      instrValid = 1'b0;
      instr      = nopWord;
      incrPC     = '0;
      seed       = 16256;
      squashNext = 1'b0;
      nextPC     = 16'h0100;
      for (int r = 0; r < 8; r++) begin
         refRegs[r] = '0;
      end
      buildTable();
      cycleLimit = rowInstr.size() + resetCycles + 20;

      // Commit and redirect stay low throughout reset
      @(negedge clk);
      rstN = 1'b0;
      repeat (resetCycles) begin
         @(negedge clk);
         checkCommit(1'b0, '0, '0, -1);
         checkRedirect(1'b0, '0, -1);
      end
      rstN = 1'b1;

      // Row i driven here and checked two falling edges later
      for (int i = 0; i < rowInstr.size() + 2; i++) begin
         @(negedge clk);
         checkAsserts();
         if (i >= 2) begin
            checkCommit(rowWbEn[i-2], rowDest[i-2], rowData[i-2], i - 2);
            checkRedirect(rowPcSrc[i-2], rowNewPC[i-2], i - 2);
         end else begin
            checkCommit(1'b0, '0, '0, -1);
            checkRedirect(1'b0, '0, -1);
         end
         if (i < rowInstr.size()) begin
            instrValid = 1'b1;
            instr      = rowInstr[i];
            incrPC     = rowPC[i];
         end else begin
            instrValid = 1'b0;
            instr      = nopWord;
            incrPC     = '0;
         end
      end
      @(negedge clk);
      if (dut_i.assertChk.failCount != 0) begin
         $display("A bound assertion on datapathTop failed in the last cycle");
         stopRun();
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: compile.f
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/forwardUnit.sv
hdl/aluCore.sv
hdl/executeStage.sv
hdl/datapathTop.sv
testbench/datapathTop_chk.sv
testbench/datapathTb.sv

// File: runSim.sh
#!/bin/sh
# Build the testbench with Verilator and run it, the exit status is the result
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert --timescale 1ns/1ps \
      --top-module datapathTb -f compile.f -o simv \
   && ./obj_dir/simv +verilator+error+limit+10 \
   || exit 1
